// ==== hdl/vga_pkg.sv ====
// vga package: mode timing, frame window geometry, RAM sizing, palette and shared types
package vga_pkg;

  // reduced mode so a frame fits in a short simulation
  localparam int HSIZE = 64;
  localparam int HFP   = 68;
  localparam int HSP   = 72;
  localparam int HMAX  = 80;
  localparam int VSIZE = 24;
  localparam int VFP   = 25;
  localparam int VSP   = 27;
  localparam int VMAX  = 30;

  // sync active polarity
  localparam logic HSPP = 1'b1;
  localparam logic VSPP = 1'b1;

  // frame window inside the visible area
  localparam int FRAME_LEFT   = 8;
  localparam int FRAME_RIGHT  = 56;
  localparam int FRAME_TOP    = 6;
  localparam int FRAME_BOTTOM = 18;
  localparam int FRAME_W      = FRAME_RIGHT - FRAME_LEFT;
  localparam int FRAME_H      = FRAME_BOTTOM - FRAME_TOP;

  // two halves, one shown and one written
  localparam int PART_SIZE = FRAME_W * FRAME_H;
  localparam int RAM_DEPTH = 2 * PART_SIZE;

  // counter to port latency
  localparam int SCAN_DELAY      = 4;
  localparam int RST_SCREEN_COLS = 16;
  localparam int SWAP_COL        = 8;

  typedef logic [11:0] coord_t;
  typedef logic [10:0] ram_addr_t;
  // index 0 doubles as "no write"
  typedef logic [2:0]  pal_idx_t;
  // 0 full brightness, 63 darkest
  typedef logic [5:0]  night_t;
  typedef logic [7:0]  chan_t;
  // red in the top byte
  typedef logic [23:0] rgb_t;

  localparam rgb_t PALETTE [8] = '{
    24'h000000,
    24'hFF0000,
    24'h00FF00,
    24'h0000FF,
    24'hFFFF00,
    24'h00FFFF,
    24'hFF00FF,
    24'hFFFFFF
  };

endpackage

// ==== hdl/scan_timing.sv ====
// scan timing: pixel counters, coordinate delay line, sync/enable and buffer swap
`timescale 1ns/1ps

module scan_timing (
  input  logic            clk_vga,
  input  logic            rst_n,
  output vga_pkg::coord_t read_x,
  output vga_pkg::coord_t read_y,
  output vga_pkg::coord_t out_x,
  output vga_pkg::coord_t out_y,
  output logic            read_part,
  output logic            rst_screen,
  output logic            hsync,
  output logic            vsync,
  output logic            data_enable
);
  import vga_pkg::*;

  // entry 0 is the live counter, the last one lines up with the output register
  coord_t line_x [SCAN_DELAY];
  coord_t line_y [SCAN_DELAY];

  assign read_x = line_x[0];
  assign read_y = line_y[0];
  assign out_x  = line_x[SCAN_DELAY-1];
  assign out_y  = line_y[SCAN_DELAY-1];

  always_ff @(posedge clk_vga) begin
    if (!rst_n) begin
      for (int i = 0; i < SCAN_DELAY; i++) begin
        line_x[i] <= '0;
        line_y[i] <= '0;
      end
    end else begin
      if (line_x[0] == coord_t'(HMAX - 1)) begin
        line_x[0] <= '0;
        if (line_y[0] == coord_t'(VMAX - 1)) line_y[0] <= '0;
        else line_y[0] <= line_y[0] + 1'b1;
      end else begin
        line_x[0] <= line_x[0] + 1'b1;
      end
      for (int i = 1; i < SCAN_DELAY; i++) begin
        line_x[i] <= line_x[i-1];
        line_y[i] <= line_y[i-1];
      end
    end
  end

  // new frame marker at the top of vertical blanking
  assign rst_screen = (read_y == coord_t'(VSIZE)) && (read_x < coord_t'(RST_SCREEN_COLS));

  always_ff @(posedge clk_vga) begin
    if (!rst_n) begin
      hsync       <= !HSPP;
      vsync       <= !VSPP;
      data_enable <= 1'b0;
      read_part   <= 1'b0;
    end else begin
      hsync <= (out_x >= coord_t'(HFP) && out_x < coord_t'(HSP)) ? HSPP : !HSPP;
      vsync <= (out_y >= coord_t'(VFP) && out_y < coord_t'(VSP)) ? VSPP : !VSPP;
      data_enable <= (out_x < coord_t'(HSIZE)) && (out_y < coord_t'(VSIZE));
      if (read_y == coord_t'(VSIZE) && read_x == coord_t'(SWAP_COL)) read_part <= ~read_part;
    end
  end

  // halves only swap inside the screen reset pulse, so no write can straddle a swap
  a_swap_in_pulse: assert property (@(posedge clk_vga) disable iff (!rst_n)
    (read_part != $past(read_part)) |-> $past(rst_screen) && (read_y == coord_t'(VSIZE)))
    else $error("buffer swap outside screen reset row");

endmodule

// ==== hdl/pixel_writer.sv ====
// pixel writer: filters write strobes and holds one back-buffer write until granted
`timescale 1ns/1ps

module pixel_writer (
  input  logic               clk_vga,
  input  logic               rst_n,
  input  logic               write_strobe,
  input  vga_pkg::coord_t    write_x,
  input  vga_pkg::coord_t    write_y,
  input  vga_pkg::pal_idx_t  write_palette,
  input  logic               read_part,
  input  logic               rst_screen,
  input  logic               write_grant,
  output vga_pkg::ram_addr_t wr_addr,
  output vga_pkg::pal_idx_t  wr_data,
  output logic               write_busy
);
  import vga_pkg::*;

  logic      take;
  ram_addr_t back_base;
  ram_addr_t next_addr;

  // transparent index, out-of-window and frame-swap strobes are dropped
  assign take = write_strobe && !write_busy && !rst_screen
             && (write_palette != '0)
             && (write_x < coord_t'(FRAME_W))
             && (write_y < coord_t'(FRAME_H));

  // writer always targets the half not being scanned
  assign back_base = read_part ? ram_addr_t'(0) : ram_addr_t'(PART_SIZE);
  assign next_addr = back_base + ram_addr_t'(write_y * FRAME_W) + ram_addr_t'(write_x);

  always_ff @(posedge clk_vga) begin
    if (!rst_n) begin
      write_busy <= 1'b0;
    end else if (take) begin
      write_busy <= 1'b1;
    end else if (write_grant) begin
      write_busy <= 1'b0;
    end
  end

  // pending entry
  always_ff @(posedge clk_vga) begin
    if (take) begin
      wr_addr <= next_addr;
      wr_data <= write_palette;
    end
  end

  a_no_strobe_busy: assert property (@(posedge clk_vga) disable iff (!rst_n)
    write_strobe |-> !write_busy)
    else $error("write strobe while a write is pending");

endmodule

// ==== hdl/frame_arbiter.sv ====
// frame arbiter: shares the single RAM port, scanout reads ahead of writer writes
`timescale 1ns/1ps

module frame_arbiter (
  input  logic               clk_vga,
  input  logic               rst_n,
  input  vga_pkg::coord_t    read_x,
  input  vga_pkg::coord_t    read_y,
  input  logic               read_part,
  input  logic               write_busy,
  input  vga_pkg::ram_addr_t wr_addr,
  input  vga_pkg::pal_idx_t  wr_data,
  output logic               write_grant,
  output vga_pkg::ram_addr_t ram_addr,
  output vga_pkg::pal_idx_t  ram_wdata,
  output logic               ram_we,
  output logic               read_valid
);
  import vga_pkg::*;

  logic      read_req;
  coord_t    win_col;
  coord_t    win_row;
  ram_addr_t rd_addr;

  assign read_req = (read_x >= coord_t'(FRAME_LEFT)) && (read_x < coord_t'(FRAME_RIGHT))
                 && (read_y >= coord_t'(FRAME_TOP)) && (read_y < coord_t'(FRAME_BOTTOM));

  assign win_col = read_x - coord_t'(FRAME_LEFT);
  assign win_row = read_y - coord_t'(FRAME_TOP);
  assign rd_addr = (read_part ? ram_addr_t'(PART_SIZE) : ram_addr_t'(0))
                 + ram_addr_t'(win_row * FRAME_W) + ram_addr_t'(win_col);

  // writer only gets the port when scanout leaves it idle
  assign write_grant = write_busy && !read_req;
  assign ram_addr    = read_req ? rd_addr : wr_addr;
  assign ram_wdata   = wr_data;
  assign ram_we      = write_grant;

  always_ff @(posedge clk_vga) begin
    if (!rst_n) read_valid <= 1'b0;
    else read_valid <= read_req;
  end

  // a pending write is served within one window line of reads
  a_write_wait: assert property (@(posedge clk_vga) disable iff (!rst_n)
    write_busy |-> ##[0:FRAME_W] write_grant)
    else $error("pending write starved by scanout reads");

endmodule

// ==== hdl/frame_ram.sv ====
// frame RAM: single-port palette index store, write on the edge, registered read
`timescale 1ns/1ps

module frame_ram (
  input  logic               clk_vga,
  input  vga_pkg::ram_addr_t ram_addr,
  input  vga_pkg::pal_idx_t  ram_wdata,
  input  logic               ram_we,
  output vga_pkg::pal_idx_t  ram_rdata
);
  import vga_pkg::*;

  // lower half is part 0, upper half part 1
  pal_idx_t mem [RAM_DEPTH];

  always_ff @(posedge clk_vga) begin
    if (ram_we) begin
      mem[ram_addr] <= ram_wdata;
    end
    ram_rdata <= mem[ram_addr];
  end

endmodule

// ==== hdl/palette_shader.sv ====
// palette shader: palette lookup, night dimming and window/background/blank select
`timescale 1ns/1ps

module palette_shader (
  input  logic              clk_vga,
  input  logic              rst_n,
  input  vga_pkg::pal_idx_t ram_rdata,
  input  logic              read_valid,
  input  vga_pkg::coord_t   out_x,
  input  vga_pkg::coord_t   out_y,
  input  vga_pkg::night_t   night_rate,
  output vga_pkg::chan_t    red,
  output vga_pkg::chan_t    green,
  output vga_pkg::chan_t    blue
);
  import vga_pkg::*;

  rgb_t base_rgb;
  rgb_t win_rgb;
  rgb_t bg_rgb;
  logic in_window;
  logic visible;

  // c - c*n/64, truncated
  function automatic chan_t dim_chan(input chan_t c, input night_t n);
    logic [13:0] prod;
    prod = c * n;
    return c - prod[13:6];
  endfunction

  function automatic rgb_t dim_rgb(input rgb_t c, input night_t n);
    return {dim_chan(c[23:16], n), dim_chan(c[15:8], n), dim_chan(c[7:0], n)};
  endfunction

  // lookup, stale RAM data turns black
  always_ff @(posedge clk_vga) begin
    base_rgb <= read_valid ? PALETTE[ram_rdata] : PALETTE[0];
  end

  // dimming, background is always index 7
  always_ff @(posedge clk_vga) begin
    win_rgb <= dim_rgb(base_rgb, night_rate);
    bg_rgb  <= dim_rgb(PALETTE[7], night_rate);
  end

  assign in_window = (out_x >= coord_t'(FRAME_LEFT)) && (out_x < coord_t'(FRAME_RIGHT))
                  && (out_y >= coord_t'(FRAME_TOP)) && (out_y < coord_t'(FRAME_BOTTOM));
  assign visible   = (out_x < coord_t'(HSIZE)) && (out_y < coord_t'(VSIZE));

  always_ff @(posedge clk_vga) begin
    if (!rst_n) begin
      {red, green, blue} <= '0;
    end else if (in_window) begin
      {red, green, blue} <= win_rgb;
    end else if (visible) begin
      {red, green, blue} <= bg_rgb;
    end else begin
      {red, green, blue} <= '0;
    end
  end

endmodule

// ==== hdl/vga_top.sv ====
// vga top: scanout, writer, arbiter, frame RAM and shader on one pixel clock
`timescale 1ns/1ps

module vga_top (
  input  logic              clk_vga,
  input  logic              rst_n,
  input  logic              write_strobe,
  input  vga_pkg::coord_t   write_x,
  input  vga_pkg::coord_t   write_y,
  input  vga_pkg::pal_idx_t write_palette,
  input  vga_pkg::night_t   night_rate,
  output logic              write_busy,
  output logic              rst_screen,
  output logic              hsync,
  output logic              vsync,
  output logic              data_enable,
  output vga_pkg::chan_t    red,
  output vga_pkg::chan_t    green,
  output vga_pkg::chan_t    blue
);
  import vga_pkg::*;

  coord_t    read_x;
  coord_t    read_y;
  coord_t    out_x;
  coord_t    out_y;
  logic      read_part;
  logic      write_grant;
  logic      ram_we;
  logic      read_valid;
  ram_addr_t wr_addr;
  ram_addr_t ram_addr;
  pal_idx_t  wr_data;
  pal_idx_t  ram_wdata;
  pal_idx_t  ram_rdata;

  scan_timing u_scan (
    .clk_vga     (clk_vga),
    .rst_n       (rst_n),
    .read_x      (read_x),
    .read_y      (read_y),
    .out_x       (out_x),
    .out_y       (out_y),
    .read_part   (read_part),
    .rst_screen  (rst_screen),
    .hsync       (hsync),
    .vsync       (vsync),
    .data_enable (data_enable)
  );

  pixel_writer u_writer (
    .clk_vga       (clk_vga),
    .rst_n         (rst_n),
    .write_strobe  (write_strobe),
    .write_x       (write_x),
    .write_y       (write_y),
    .write_palette (write_palette),
    .read_part     (read_part),
    .rst_screen    (rst_screen),
    .write_grant   (write_grant),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .write_busy    (write_busy)
  );

  frame_arbiter u_arb (
    .clk_vga     (clk_vga),
    .rst_n       (rst_n),
    .read_x      (read_x),
    .read_y      (read_y),
    .read_part   (read_part),
    .write_busy  (write_busy),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .write_grant (write_grant),
    .ram_addr    (ram_addr),
    .ram_wdata   (ram_wdata),
    .ram_we      (ram_we),
    .read_valid  (read_valid)
  );

  frame_ram u_ram (
    .clk_vga   (clk_vga),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we),
    .ram_rdata (ram_rdata)
  );

  palette_shader u_shader (
    .clk_vga    (clk_vga),
    .rst_n      (rst_n),
    .ram_rdata  (ram_rdata),
    .read_valid (read_valid),
    .out_x      (out_x),
    .out_y      (out_y),
    .night_rate (night_rate),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

endmodule

// ==== testbench/tb_vga_top.sv ====
// vga_top testbench with scan model, double-buffer reference and per-pixel compare
`timescale 1ns/1ps

module tb_vga_top;
  import vga_pkg::*;

  localparam int FRAME_CYC  = HMAX * VMAX;
  localparam int RUN_FRAMES = 8;

  logic      clk_vga;
  logic      rst_n;
  logic      write_strobe;
  coord_t    write_x;
  coord_t    write_y;
  pal_idx_t  write_palette;
  night_t    night_rate;
  logic      write_busy;
  logic      rst_screen;
  logic      hsync;
  logic      vsync;
  logic      data_enable;
  chan_t     red;
  chan_t     green;
  chan_t     blue;

  // model state, [0] is the live counter and [4] the position at the ports
  int        mx;
  int        my;
  int        hx [5];
  int        hy [5];
  logic      model_part;
  logic      out_reset;
  logic      accepted;
  pal_idx_t  buf_mem [2][PART_SIZE];
  logic      written [2][PART_SIZE];
  logic [31:0] rng;
  int        busy_len;
  int        err_total;
  int        test_start;
  int        pass_cnt;
  int        fail_cnt;
  string     test_name;

  vga_top dut0 (
    .clk_vga       (clk_vga),
    .rst_n         (rst_n),
    .write_strobe  (write_strobe),
    .write_x       (write_x),
    .write_y       (write_y),
    .write_palette (write_palette),
    .night_rate    (night_rate),
    .write_busy    (write_busy),
    .rst_screen    (rst_screen),
    .hsync         (hsync),
    .vsync         (vsync),
    .data_enable   (data_enable),
    .red           (red),
    .green         (green),
    .blue          (blue)
  );

  initial begin
    clk_vga = 1'b0;
    forever #4 clk_vga = ~clk_vga;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  function automatic chan_t dimmed(input chan_t c, input night_t n);
    return chan_t'(int'(c) - (int'(c) * int'(n)) / 64);
  endfunction

  // known is low for window entries never written in the shown half
  function automatic rgb_t expected_pixel(input int x, input int y, input night_t night,
                                          output bit known);
    rgb_t c;
    int   idx;
    known = 1'b1;
    if (x >= HSIZE || y >= VSIZE) return '0;
    if (x >= FRAME_LEFT && x < FRAME_RIGHT && y >= FRAME_TOP && y < FRAME_BOTTOM) begin
      idx   = (y - FRAME_TOP) * FRAME_W + (x - FRAME_LEFT);
      known = written[model_part][idx];
      c     = PALETTE[buf_mem[model_part][idx]];
    end else begin
      c = PALETTE[7];
    end
    return {dimmed(c[23:16], night), dimmed(c[15:8], night), dimmed(c[7:0], night)};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      if (err_total - test_start < 20)
        $display("[FAIL] %s %s at (%0d,%0d): expected %h actual %h",
                 test_name, what, hx[4], hy[4], expected, actual);
      err_total++;
    end
  endtask

  always @(posedge clk_vga) begin : model
    for (int i = 4; i > 0; i--) begin
      hx[i] = hx[i-1];
      hy[i] = hy[i-1];
    end
    out_reset = !rst_n;
    accepted  = 1'b0;
    if (!rst_n) begin
      mx = 0;
      my = 0;
      model_part = 1'b0;
      for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < PART_SIZE; i++) written[p][i] = 1'b0;
      end
    end else begin
      if (write_strobe && !write_busy && !(my == VSIZE && mx < RST_SCREEN_COLS)
          && write_palette != 3'd0 && int'(write_x) < FRAME_W && int'(write_y) < FRAME_H) begin
        buf_mem[!model_part][int'(write_y) * FRAME_W + int'(write_x)] = write_palette;
        written[!model_part][int'(write_y) * FRAME_W + int'(write_x)] = 1'b1;
        accepted = 1'b1;
      end
      if (my == VSIZE && mx == SWAP_COL) model_part = !model_part;
      if (mx == HMAX - 1) begin
        mx = 0;
        my = (my == VMAX - 1) ? 0 : my + 1;
      end else begin
        mx = mx + 1;
      end
    end
    hx[0] = mx;
    hy[0] = my;
  end

  always @(negedge clk_vga) begin : compare
    rgb_t exp_rgb;
    bit   known;
    if (out_reset) begin
      compare_value("reset_outputs", 32'd0, 32'({data_enable, hsync == HSPP, vsync == VSPP,
                    write_busy, red, green, blue}));
    end else begin
      compare_value("hsync", 32'(hx[4] >= HFP && hx[4] < HSP), 32'(hsync == HSPP));
      compare_value("vsync", 32'(hy[4] >= VFP && hy[4] < VSP), 32'(vsync == VSPP));
      compare_value("data_enable", 32'(hx[4] < HSIZE && hy[4] < VSIZE), 32'(data_enable));
      exp_rgb = expected_pixel(hx[4], hy[4], night_rate, known);
      if (known) compare_value("rgb", 32'(exp_rgb), 32'({red, green, blue}));
    end
    compare_value("rst_screen", 32'(my == VSIZE && mx < RST_SCREEN_COLS), 32'(rst_screen));
    if (accepted) compare_value("busy_raise", 32'd1, 32'(write_busy));
    // scanout holds the port for at most one window line
    busy_len = write_busy ? busy_len + 1 : 0;
    compare_value("busy_bound", 32'd1, 32'(busy_len <= FRAME_W + 1));
  end

  task automatic wait_pos(input int x, input int y);
    @(negedge clk_vga);
    while (mx != x || my != y) @(negedge clk_vga);
  endtask

  task automatic issue_write(input int x, input int y, input pal_idx_t pal);
    @(negedge clk_vga);
    while (write_busy) @(negedge clk_vga);
    @(posedge clk_vga);
    write_strobe  <= 1'b1;
    write_x       <= coord_t'(x);
    write_y       <= coord_t'(y);
    write_palette <= pal;
    @(posedge clk_vga);
    write_strobe  <= 1'b0;
  endtask

  // palette 0 and out-of-window coordinates come up now and then
  task automatic random_writes(input int n);
    for (int i = 0; i < n; i++) begin
      rng = xorshift(rng);
      issue_write(int'(rng[5:0]), int'(rng[11:8]), pal_idx_t'(rng[18:16]));
    end
  endtask

  task automatic set_night(input night_t n);
    @(posedge clk_vga);
    night_rate <= n;
  endtask

  task automatic next_test(input string name);
    @(posedge clk_vga);
    if (err_total == test_start) begin
      pass_cnt++;
      $display("test %s finished with no mismatches", test_name);
    end else begin
      fail_cnt++;
      $display("test %s finished with %0d mismatches", test_name, err_total - test_start);
    end
    test_name  = name;
    test_start = err_total;
  endtask

  initial begin : watchdog
    #((RUN_FRAMES * FRAME_CYC + 400) * 8);
    $display("watchdog expired before the last test finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    rst_n         <= 1'b0;
    write_strobe  <= 1'b0;
    write_x       <= '0;
    write_y       <= '0;
    write_palette <= '0;
    night_rate    <= '0;
    rng        = 32'h7b91_b61b;
    test_name  = "reset_sync";
    test_start = 0;
    repeat (3) @(posedge clk_vga);
    rst_n <= 1'b1;
    wait_pos(20, VSIZE);
    next_test("background");
    set_night(6'd32);
    wait_pos(20, VSIZE);
    set_night(6'd63);
    wait_pos(20, VSIZE);
    next_test("double_buffer");
    rng = xorshift(rng);
    set_night(night_t'(rng[5:0]));
    random_writes(60);
    issue_write(5, 3, 3'd2);
    wait_pos(20, VSIZE);
    random_writes(60);
    wait_pos(20, VSIZE);
    // entry (5,3) sits in the back half again
    next_test("write_filter");
    issue_write(5, 3, 3'd0);
    wait_pos(2, VSIZE);
    issue_write(5, 3, 3'd6);
    wait_pos(20, VSIZE);
    next_test("arbitration");
    wait_pos(FRAME_LEFT, FRAME_TOP + 1);
    random_writes(20);
    wait_pos(20, VSIZE);
    wait_pos(20, VSIZE);
    next_test("done");
    $display("tests passed %0d, failed %0d, mismatches %0d", pass_cnt, fail_cnt, err_total);
    if (fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
hdl/vga_pkg.sv
hdl/scan_timing.sv
hdl/pixel_writer.sv
hdl/frame_arbiter.sv
hdl/frame_ram.sv
hdl/palette_shader.sv
hdl/vga_top.sv
testbench/tb_vga_top.sv

// ==== Makefile ====
# Verilator build and run for the VGA scanout testbench

TOP       ?= tb_vga_top
LOG       ?= sim.log
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv testbench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP LOG FILELIST BUILD_DIR VERILATOR VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Simulation passed" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
